//--- dv/buck_modulation_trace.txt
// Columns in hex: period duty shift0 shift1 shift2 shift3 high0 high1 high2 high3
// Expected high count per phase is (period/2 + duty/2) - (period/2 - duty/2)
// Period 40, duty 12, quarter-period spacing
0028 000c 0000 000a 0014 001e 000c 000c 000c 000c
// Period 32, odd duty 17 rounds down to 16
0020 0011 0000 0008 0010 0018 0010 0010 0010 0010
// Period 48, shifts above the period wrap to 12 and 36
0030 001e 0000 003c 0018 0054 001e 001e 001e 001e
// Odd period 25, duty 7
0019 0007 0000 0005 000a 000f 0006 0006 0006 0006
// Period 60, duty 50
003c 0032 0000 000f 001e 002d 0032 0032 0032 0032

//--- all.f
+incdir+common
common/buck_pkg.sv
pre_modulation/buck_pre_modulation_processor.sv
pwm_generator/pwm_register_file.sv
pwm_generator/pwm_timebase.sv
design/buck_modulation_top.sv
dv/buck_modulation_asserts.sv
dv/buck_modulation_tb.sv

//--- Bender.yml
package:
  name: buck_modulation

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/buck_pkg.sv
      - pre_modulation/buck_pre_modulation_processor.sv
      - pwm_generator/pwm_register_file.sv
      - pwm_generator/pwm_timebase.sv
      - design/buck_modulation_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/buck_modulation_asserts.sv
      - dv/buck_modulation_tb.sv

//--- dv/buck_modulation_tb.sv
//##########################################################################
// Buck modulation testbench
// Replays the trace through update, start and stop, measures the high
// time and the phase spacing of every PWM output and checks the results
//##########################################################################

`timescale 1ns/10ps
`default_nettype none

module buck_modulation_tb;

    import buck_pkg::*;

    localparam int N_PHASES = 4;
    localparam int TRACE_LINES = 5;
    localparam int TRACE_COLUMNS = 2 + 2 * N_PHASES;
    localparam int WAIT_LIMIT = 2000;

    localparam int CMD_CONFIGURE = 0;
    localparam int CMD_START = 1;
    localparam int CMD_STOP = 2;
    localparam int CMD_UPDATE = 3;

    logic clock;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic update;
    timing_t period;
    timing_t duty;
    timing_t [N_PHASES-1:0] phase_shifts;
    logic done;
    logic modulator_status;
    logic [N_PHASES-1:0] pwm;

    logic [15:0] trace_words [TRACE_LINES * TRACE_COLUMNS];
    int error_count;
    int test_count;
    int failed_tests;
    int test_start_errors;
    int assertion_failures;
    int high_counts [N_PHASES];
    int rise_delays [N_PHASES];

    bind buck_pre_modulation_processor buck_modulation_asserts i_buck_modulation_asserts (
        .clock(clock),
        .reset(reset),
        .write_valid(write_valid),
        .write_ready(write_ready),
        .write_address(write_address),
        .write_data(write_data),
        .done(done),
        .modulator_status(modulator_status)
    );

    buck_modulation_top #(
        .N_PHASES(N_PHASES)
    ) i_buck_modulation_top (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .duty(duty),
        .phase_shifts(phase_shifts),
        .done(done),
        .modulator_status(modulator_status),
        .pwm(pwm)
    );

    always #5 clock = ~clock;

    // Columns are period, duty, shifts 0..3, expected high counts 0..3
    function automatic int trace_field(input int line, input int column);
        return int'(trace_words[line * TRACE_COLUMNS + column]);
    endfunction

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("Test %0d (%s): passed", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d (%s): failed with %0d errors", test_count, name,
                     error_count - test_start_errors);
        end
    endtask

    task automatic pulse_command(input int command);
        @(posedge clock);
        case (command)
            CMD_CONFIGURE: configure <= 1'b1;
            CMD_START: start <= 1'b1;
            CMD_STOP: stop <= 1'b1;
            default: update <= 1'b1;
        endcase
        @(posedge clock);
        configure <= 1'b0;
        start <= 1'b0;
        stop <= 1'b0;
        update <= 1'b0;
    endtask

    task automatic apply_trace_line(input int line);
        @(posedge clock);
        period <= timing_t'(trace_field(line, 0));
        duty <= timing_t'(trace_field(line, 1));
        for (int k = 0; k < N_PHASES; k++) begin
            phase_shifts[k] <= timing_t'(trace_field(line, 2 + k));
        end
    endtask

    task automatic wait_for_done(input string what, input bit watch_pwm);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
            if (watch_pwm) begin
                compare_values("pwm", pwm, 0);
            end
            seen = (done === 1'b1);
        end
        if (!seen) begin
            $display("Timeout: done never pulsed after %s", what);
            error_count++;
        end
    endtask

    // Starts at a rising edge of phase 0 and samples exactly one period
    task automatic measure_outputs(input int line_period);
        logic [N_PHASES-1:0] previous;
        int cycles;
        bit found;
        repeat (4) @(negedge clock);
        previous = pwm;
        cycles = 0;
        found = 1'b0;
        for (int k = 0; k < N_PHASES; k++) begin
            high_counts[k] = 0;
            // A delay equal to the period marks a phase that never rose
            rise_delays[k] = line_period;
        end
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
            found = (pwm[0] === 1'b1) && (previous[0] === 1'b0);
            if (!found) begin
                previous = pwm;
            end
        end
        if (!found) begin
            $display("Timeout: pwm[0] never rose while the modulator was running");
            error_count++;
        end else begin
            for (int j = 0; j < line_period; j++) begin
                if (j > 0) begin
                    @(negedge clock);
                end
                for (int k = 0; k < N_PHASES; k++) begin
                    if (pwm[k] === 1'b1) begin
                        high_counts[k]++;
                        if (previous[k] === 1'b0 && rise_delays[k] == line_period) begin
                            rise_delays[k] = j;
                        end
                    end
                end
                previous = pwm;
            end
        end
    endtask

    task automatic check_high_counts(input int line);
        for (int k = 0; k < N_PHASES; k++) begin
            compare_values($sformatf("pwm[%0d] high count", k), high_counts[k],
                           trace_field(line, 2 + N_PHASES + k));
        end
    endtask

    // Phase k rises (offset 0 - offset k) mod period cycles after phase 0
    task automatic check_phase_delays(input int line);
        int p;
        int first_offset;
        int offset;
        p = trace_field(line, 0);
        first_offset = trace_field(line, 2) % p;
        for (int k = 1; k < N_PHASES; k++) begin
            offset = trace_field(line, 2 + k) % p;
            compare_values($sformatf("pwm[%0d] rise delay", k), rise_delays[k],
                           (first_offset - offset + p) % p);
        end
    endtask

    task automatic start_and_check();
        pulse_command(CMD_START);
        @(negedge clock);
        compare_values("modulator_status", modulator_status, 1);
    endtask

    initial begin
        int zero_cycles;
        clock = 1'b0;
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        period = '0;
        duty = '0;
        phase_shifts = '0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        $readmemh("dv/buck_modulation_trace.txt", trace_words);
        repeat (5) @(posedge clock);
        reset <= 1'b1;

        begin_test();
        repeat (20) begin
            @(negedge clock);
            compare_values("done", done, 0);
            compare_values("modulator_status", modulator_status, 0);
            compare_values("pwm", pwm, 0);
        end
        end_test("idle after reset");

        begin_test();
        apply_trace_line(0);
        pulse_command(CMD_UPDATE);
        wait_for_done("the update of trace line 0", 1'b1);
        start_and_check();
        measure_outputs(trace_field(0, 0));
        check_high_counts(0);
        end_test("high counts of trace line 0");
        begin_test();
        check_phase_delays(0);
        end_test("phase spacing of trace line 0");

        for (int line = 1; line < TRACE_LINES; line++) begin
            // The new values stay latched while the modulator runs
            begin_test();
            apply_trace_line(line);
            pulse_command(CMD_UPDATE);
            measure_outputs(trace_field(line - 1, 0));
            check_high_counts(line - 1);
            pulse_command(CMD_STOP);
            @(negedge clock);
            compare_values("modulator_status", modulator_status, 0);
            wait_for_done($sformatf("the deferred update of trace line %0d", line), 1'b0);
            compare_values("pwm", pwm, 0);
            end_test($sformatf("deferred update of trace line %0d", line));

            begin_test();
            start_and_check();
            measure_outputs(trace_field(line, 0));
            check_high_counts(line);
            end_test($sformatf("high counts of trace line %0d", line));
            begin_test();
            check_phase_delays(line);
            end_test($sformatf("phase spacing of trace line %0d", line));
        end

        begin_test();
        pulse_command(CMD_STOP);
        @(negedge clock);
        compare_values("modulator_status", modulator_status, 0);
        zero_cycles = 0;
        while (pwm !== '0 && zero_cycles < trace_field(TRACE_LINES - 1, 0)) begin
            @(negedge clock);
            zero_cycles++;
        end
        if (pwm !== '0) begin
            $display("Timeout: pwm did not return to zero within one period after stop");
            error_count++;
        end
        end_test("stop");

        // The working thresholds of the last line are still loaded here
        begin_test();
        pulse_command(CMD_CONFIGURE);
        wait_for_done("configure", 1'b1);
        end_test("configure");

        assertion_failures =
            i_buck_modulation_top.i_buck_pre_modulation_processor.i_buck_modulation_asserts.failure_count;
        if (assertion_failures > 0) begin
            $display("Bound assertions failed %0d times", assertion_failures);
            error_count += assertion_failures;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/buck_modulation_asserts.sv
//##########################################################################
// Buck modulation assertions
// Write bus protocol, done pulse width and control outputs after reset,
// bound to the pre-modulation processor
//##########################################################################

`timescale 1ns/10ps
`default_nettype none

module buck_modulation_asserts (
    input wire                      clock,
    input wire                      reset,
    input wire                      write_valid,
    input wire                      write_ready,
    input wire buck_pkg::reg_addr_t write_address,
    input wire buck_pkg::reg_data_t write_data,
    input wire                      done,
    input wire                      modulator_status
);

    // Read by the testbench at the end of the run
    int failure_count = 0;

    // A write that is not accepted keeps its payload until the transfer
    write_payload_held: assert property (
        @(posedge clock) disable iff (!reset)
        write_valid && !write_ready |=>
            write_valid && $stable(write_address) && $stable(write_data)
    ) else begin
        failure_count++;
        $error("write bus payload changed before the register file accepted it");
    end

    done_single_cycle: assert property (
        @(posedge clock) disable iff (!reset)
        done |=> !done
    ) else begin
        failure_count++;
        $error("done stayed high for more than one cycle");
    end

    // First cycle out of reset
    quiet_after_reset: assert property (
        @(posedge clock)
        $rose(reset) |-> !write_valid && !modulator_status
    ) else begin
        failure_count++;
        $error("write_valid or modulator_status high in the cycle after reset");
    end

endmodule

`default_nettype wire

//--- design/buck_modulation_top.sv
//##########################################################################
// Buck modulation top level
// Pre-modulation processor driving the PWM register file over the write
// bus, and the timebase that turns the working registers into PWM
//##########################################################################

`timescale 1ns/10ps
`default_nettype none

module buck_modulation_top #(
    parameter int N_PHASES = 4
) (
    input  wire                                   clock,
    input  wire                                   reset,
    input  wire                                   configure,
    input  wire                                   start,
    input  wire                                   stop,
    input  wire                                   update,
    input  wire buck_pkg::timing_t                period,
    input  wire buck_pkg::timing_t                duty,
    input  wire buck_pkg::timing_t [N_PHASES-1:0] phase_shifts,
    output logic                                  done,
    output logic                                  modulator_status,
    output logic [N_PHASES-1:0]                   pwm
);

    import buck_pkg::*;

    logic write_valid;
    logic write_ready;
    reg_addr_t write_address;
    reg_data_t write_data;
    logic enable;
    logic period_end;
    timing_t working_period;
    timing_t [N_PHASES-1:0] low_thresholds;
    timing_t [N_PHASES-1:0] high_thresholds;
    timing_t [N_PHASES-1:0] offsets;

    buck_pre_modulation_processor #(
        .N_PHASES(N_PHASES)
    ) i_buck_pre_modulation_processor (
        .clock(clock),
        .reset(reset),
        .configure(configure),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .duty(duty),
        .phase_shifts(phase_shifts),
        .write_ready(write_ready),
        .write_valid(write_valid),
        .write_address(write_address),
        .write_data(write_data),
        .done(done),
        .modulator_status(modulator_status)
    );

    pwm_register_file #(
        .N_PHASES(N_PHASES)
    ) i_pwm_register_file (
        .clock(clock),
        .reset(reset),
        .write_valid(write_valid),
        .write_address(write_address),
        .write_data(write_data),
        .period_end(period_end),
        .write_ready(write_ready),
        .enable(enable),
        .period(working_period),
        .low_thresholds(low_thresholds),
        .high_thresholds(high_thresholds),
        .offsets(offsets)
    );

    pwm_timebase #(
        .N_PHASES(N_PHASES)
    ) i_pwm_timebase (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .period(working_period),
        .low_thresholds(low_thresholds),
        .high_thresholds(high_thresholds),
        .offsets(offsets),
        .pwm(pwm),
        .period_end(period_end)
    );

endmodule

`default_nettype wire

//--- pwm_generator/pwm_timebase.sv
//##########################################################################
// PWM timebase
// One wrapping counter per phase, started at its offset, and a registered
// window compare that forms each PWM output
//##########################################################################

`timescale 1ns/10ps
`default_nettype none

module pwm_timebase #(
    parameter int N_PHASES = 4
) (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire                                  enable,
    input  wire buck_pkg::timing_t               period,
    input  wire buck_pkg::timing_t [N_PHASES-1:0] low_thresholds,
    input  wire buck_pkg::timing_t [N_PHASES-1:0] high_thresholds,
    input  wire buck_pkg::timing_t [N_PHASES-1:0] offsets,
    output logic [N_PHASES-1:0]                  pwm,
    output logic                                 period_end
);

    import buck_pkg::*;

    timing_t counters [N_PHASES];
    logic [N_PHASES-1:0] wrap;
    logic enable_d;
    logic enable_rise;

    assign enable_rise = enable & ~enable_d;

    // The extra bit keeps the compare correct for a zero or full-scale period
    always_comb begin
        for (int k = 0; k < N_PHASES; k++) begin
            wrap[k] = ({1'b0, counters[k]} + 1'b1) >= {1'b0, period};
        end
    end

    // Phase 0 sets the period boundary for the register commit
    assign period_end = enable & enable_d & wrap[0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_d <= 1'b0;
            pwm <= '0;
            for (int k = 0; k < N_PHASES; k++) begin
                counters[k] <= '0;
            end
        end else begin
            enable_d <= enable;
            for (int k = 0; k < N_PHASES; k++) begin
                if (enable_rise) begin
                    counters[k] <= offsets[k];
                end else if (enable) begin
                    counters[k] <= wrap[k] ? '0 : counters[k] + 1'b1;
                end
                // Held counters are stale in the enable cycle, so the output waits one more
                pwm[k] <= enable & enable_d
                          & (counters[k] >= low_thresholds[k])
                          & (counters[k] < high_thresholds[k]);
            end
        end
    end

endmodule

`default_nettype wire

//--- pwm_generator/pwm_register_file.sv
//##########################################################################
// PWM register file
// Double-buffered registers behind the write bus. Shadows commit to the
// working copies at the period boundary or whenever outputs are disabled
//##########################################################################

`timescale 1ns/10ps
`include "buck_consts.svh"
`default_nettype none

module pwm_register_file #(
    parameter int N_PHASES = 4
) (
    input  wire                                  clock,
    input  wire                                  reset,
    input  wire                                  write_valid,
    input  wire buck_pkg::reg_addr_t             write_address,
    input  wire buck_pkg::reg_data_t             write_data,
    input  wire                                  period_end,
    output logic                                 write_ready,
    output logic                                 enable,
    output buck_pkg::timing_t                    period,
    output buck_pkg::timing_t [N_PHASES-1:0]     low_thresholds,
    output buck_pkg::timing_t [N_PHASES-1:0]     high_thresholds,
    output buck_pkg::timing_t [N_PHASES-1:0]     offsets
);

    import buck_pkg::*;

    // Slot 0 holds the period, slot 1 + 3k + f holds field f of phase k
    localparam int SLOTS = 1 + 3 * N_PHASES;

    logic [SLOTS-1:0] write_select;
    logic [SLOTS-1:0] pending;
    logic ctrl_select;
    logic write_accept;
    logic commit;
    reg_data_t shadow [SLOTS];
    reg_data_t working [SLOTS];

    always_comb begin
        write_select = '0;
        write_select[0] = (write_address == `PWM_PERIOD_ADDR);
        for (int k = 0; k < N_PHASES; k++) begin
            for (int f = 0; f < 3; f++) begin
                write_select[1 + 3 * k + f] =
                    (write_address == reg_addr_t'(`PWM_CMP_BASE_ADDR + 4 * k + f));
            end
        end
    end

    assign ctrl_select = (write_address == `PWM_CTRL_ADDR);
    // A second write to a slot that has not committed yet must wait
    assign write_ready = ~|(write_select & pending);
    assign write_accept = write_valid & write_ready;
    assign commit = period_end | ~enable;

    always_ff @(posedge clock) begin
        for (int s = 0; s < SLOTS; s++) begin
            if (write_accept && write_select[s]) begin
                shadow[s] <= write_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
            pending <= '0;
            for (int s = 0; s < SLOTS; s++) begin
                working[s] <= '0;
            end
        end else begin
            if (write_accept && ctrl_select) begin
                enable <= write_data[`PWM_CTRL_ENABLE_BIT];
            end
            if (commit) begin
                for (int s = 0; s < SLOTS; s++) begin
                    if (pending[s]) begin
                        working[s] <= shadow[s];
                    end
                end
            end
            pending <= (pending & {SLOTS{~commit}}) | (write_select & {SLOTS{write_accept}});
        end
    end

    always_comb begin
        period = working[0];
        for (int k = 0; k < N_PHASES; k++) begin
            low_thresholds[k] = working[1 + 3 * k];
            high_thresholds[k] = working[2 + 3 * k];
            offsets[k] = working[3 + 3 * k];
        end
    end

endmodule

`default_nettype wire

//--- pre_modulation/buck_pre_modulation_processor.sv
//##########################################################################
// Buck pre-modulation processor
// Turns period, duty and phase shifts into compare thresholds and offsets
// and writes them, with the setup and on/off words, to the PWM generator
//##########################################################################

`timescale 1ns/10ps
`include "buck_consts.svh"
`default_nettype none

module buck_pre_modulation_processor #(
    parameter int N_PHASES = 4
) (
    input  wire                                    clock,
    input  wire                                    reset,
    input  wire                                    configure,
    input  wire                                    start,
    input  wire                                    stop,
    input  wire                                    update,
    input  wire buck_pkg::timing_t                 period,
    input  wire buck_pkg::timing_t                 duty,
    input  wire buck_pkg::timing_t [N_PHASES-1:0]  phase_shifts,
    input  wire                                    write_ready,
    output logic                                   write_valid,
    output buck_pkg::reg_addr_t                    write_address,
    output buck_pkg::reg_data_t                    write_data,
    output logic                                   done,
    output logic                                   modulator_status
);

    import buck_pkg::*;

    localparam int UPDATE_WORDS = 1 + 3 * N_PHASES;
    localparam int INDEX_WIDTH = $clog2(UPDATE_WORDS);
    localparam int MAP_WIDTH = UPDATE_WORDS * `BUCK_ADDR_WIDTH;

    // Word 0 is the period, then low, high and offset of phase 0 upward
    function automatic logic [MAP_WIDTH-1:0] update_address_map();
        logic [MAP_WIDTH-1:0] map;
        map = '0;
        map[0 +: `BUCK_ADDR_WIDTH] = `PWM_PERIOD_ADDR;
        for (int k = 0; k < N_PHASES; k++) begin
            for (int f = 0; f < 3; f++) begin
                map[(1 + 3 * k + f) * `BUCK_ADDR_WIDTH +: `BUCK_ADDR_WIDTH] =
                    reg_addr_t'(`PWM_CMP_BASE_ADDR + 4 * k + f);
            end
        end
        return map;
    endfunction

    localparam logic [MAP_WIDTH-1:0] UPDATE_ADDRESSES = update_address_map();

    premod_state_t state;
    logic [INDEX_WIDTH-1:0] word_index;
    logic [INDEX_WIDTH-1:0] next_index;
    logic update_pending;
    logic write_accept;
    reg_addr_t config_next_address;
    reg_data_t config_next_data;
    reg_data_t update_words [1:UPDATE_WORDS-1];
    timing_t half_period;
    timing_t half_duty;

    assign write_accept = write_valid & write_ready;
    assign next_index = word_index + 1'b1;
    assign half_period = period >> 1;
    assign half_duty = duty >> 1;

    // Configuration leaves the generator disabled, loads the period and
    // parks phase 0 with a zero high threshold
    always_comb begin
        if (next_index == INDEX_WIDTH'(1)) begin
            config_next_address = `PWM_PERIOD_ADDR;
            config_next_data = period;
        end else begin
            config_next_address = reg_addr_t'(`PWM_CMP_BASE_ADDR + 1);
            config_next_data = '0;
        end
    end

    // All compare words come from the inputs seen in the calculate cycle
    always_ff @(posedge clock) begin
        if (state == premod_calculate) begin
            for (int k = 0; k < N_PHASES; k++) begin
                update_words[1 + 3 * k] <= half_period - half_duty;
                update_words[2 + 3 * k] <= half_period + half_duty;
                update_words[3 + 3 * k] <= (period == '0) ? '0 : phase_shifts[k] % period;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= premod_idle;
            word_index <= '0;
            write_valid <= 1'b0;
            done <= 1'b0;
            modulator_status <= 1'b0;
            update_pending <= 1'b0;
        end else begin
            done <= 1'b0;
            update_pending <= update_pending | update;
            case (state)
                premod_idle: begin
                    if (start) begin
                        modulator_status <= 1'b1;
                        write_valid <= 1'b1;
                        write_address <= `PWM_CTRL_ADDR;
                        write_data <= `PWM_CTRL_ON;
                        state <= premod_wait_accept;
                    end else if (stop) begin
                        modulator_status <= 1'b0;
                        write_valid <= 1'b1;
                        write_address <= `PWM_CTRL_ADDR;
                        write_data <= `PWM_CTRL_OFF;
                        state <= premod_wait_accept;
                    end else if (configure) begin
                        modulator_status <= 1'b0;
                        word_index <= '0;
                        write_valid <= 1'b1;
                        write_address <= `PWM_CTRL_ADDR;
                        write_data <= `PWM_CTRL_OFF;
                        state <= premod_configure;
                    end else if ((update_pending | update) && !modulator_status) begin
                        // A running modulator keeps the request latched until a stop
                        update_pending <= 1'b0;
                        state <= premod_calculate;
                    end
                end
                premod_configure: begin
                    if (write_accept) begin
                        if (word_index == INDEX_WIDTH'(`PWM_CFG_WORDS - 1)) begin
                            write_valid <= 1'b0;
                            done <= 1'b1;
                            state <= premod_idle;
                        end else begin
                            word_index <= next_index;
                            write_address <= config_next_address;
                            write_data <= config_next_data;
                        end
                    end
                end
                premod_calculate: begin
                    word_index <= '0;
                    write_valid <= 1'b1;
                    write_address <= UPDATE_ADDRESSES[0 +: `BUCK_ADDR_WIDTH];
                    write_data <= period;
                    state <= premod_write_update;
                end
                premod_write_update: begin
                    if (write_accept) begin
                        if (word_index == INDEX_WIDTH'(UPDATE_WORDS - 1)) begin
                            write_valid <= 1'b0;
                            done <= 1'b1;
                            state <= premod_idle;
                        end else begin
                            word_index <= next_index;
                            write_address <=
                                UPDATE_ADDRESSES[next_index * `BUCK_ADDR_WIDTH +: `BUCK_ADDR_WIDTH];
                            write_data <= update_words[next_index];
                        end
                    end
                end
                premod_wait_accept: begin
                    if (write_accept) begin
                        write_valid <= 1'b0;
                        state <= premod_idle;
                    end
                end
                default: begin
                    write_valid <= 1'b0;
                    state <= premod_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/buck_pkg.sv
//##########################################################################
// Buck modulation package
// Vector types for timing values and the register bus, and the state
// encoding of the pre-modulation processor
//##########################################################################

`include "buck_consts.svh"
`default_nettype none

package buck_pkg;

    // Period, duty, compare threshold or counter offset, in clock cycles
    typedef logic [`BUCK_DATA_WIDTH-1:0] timing_t;

    // Register write bus
    typedef logic [`BUCK_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`BUCK_DATA_WIDTH-1:0] reg_data_t;

    // Sequencer states of the pre-modulation processor
    typedef enum logic [2:0] {
        // Waiting for a command
        premod_idle,
        // Streaming the configuration words
        premod_configure,
        // Deriving thresholds and offsets from the inputs
        premod_calculate,
        // Streaming period and per-phase compare words
        premod_write_update,
        // A single on or off write is outstanding
        premod_wait_accept
    } premod_state_t;

endpackage

`default_nettype wire

//--- common/buck_consts.svh
//##########################################################################
// Buck modulation constants
// Widths, the PWM generator register map and the control words that the
// pre-modulation processor writes over the register bus
//##########################################################################

`ifndef BUCK_CONSTS_SVH
`define BUCK_CONSTS_SVH

// Timing values and write data share one width
`define BUCK_DATA_WIDTH 16
`define BUCK_ADDR_WIDTH 8

// Register map of the PWM generator
`define PWM_CTRL_ADDR 8'h00
`define PWM_PERIOD_ADDR 8'h01

// Phase k owns four addresses from here: low, high, offset and one spare
`define PWM_CMP_BASE_ADDR 8'h10

// Control register layout and the two words the processor uses
`define PWM_CTRL_ENABLE_BIT 0
`define PWM_CTRL_ON 16'h0001
`define PWM_CTRL_OFF 16'h0000

// Length of the configuration sequence
`define PWM_CFG_WORDS 3

`endif
